//--- design/addend_lane.sv
`timescale 1ns/1ps
`default_nettype none

module addend_lane
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,

   input  logic                           iss_v_i,
   input  mac_pkg::mac_op_e               iss_op_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] iss_rd_i,
   input  logic [mac_pkg::DATA_W-1:0]     iss_imm_i,
   input  logic [mac_pkg::DATA_W-1:0]     rs3_data_i,

   output logic                           add_v_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] add_rd_o,
   output logic [mac_pkg::DATA_W-1:0]     addend_o
);

   logic                           v_q;
   mac_pkg::mac_op_e               op_q;
   logic [mac_pkg::REG_ADDR_W-1:0] rd_q;
   logic [mac_pkg::DATA_W-1:0]     imm_q;
   logic [mac_pkg::DATA_W-1:0]     addend_d;

   always_comb
   begin
      case (op_q)
         mac_pkg::OP_MADD: addend_d = rs3_data_i;
         // two's complement negation
         mac_pkg::OP_MSUB: addend_d = ~rs3_data_i + 1'b1;
         mac_pkg::OP_MUL:  addend_d = '0;
         default:          addend_d = imm_q;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         v_q     <= 1'b0;
         add_v_o <= 1'b0;
      end
      else
      begin
         v_q     <= iss_v_i;
         add_v_o <= v_q;
      end
   end

   // issue fields line up with the read data
   always_ff @(posedge clk_i)
   begin
      if (iss_v_i)
      begin
         op_q  <= iss_op_i;
         rd_q  <= iss_rd_i;
         imm_q <= iss_imm_i;
      end
   end

   // destination rides along with the addend
   always_ff @(posedge clk_i)
   begin
      if (v_q)
      begin
         addend_o <= addend_d;
         add_rd_o <= rd_q;
      end
   end

endmodule

`default_nettype wire

//--- design/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,

   input  logic                           in_valid_i,
   input  mac_pkg::mac_op_e               in_op_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rd_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rs1_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rs2_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rs3_i,
   input  logic [mac_pkg::DATA_W-1:0]     in_imm_i,
   output logic                           in_credit_o,

   input  logic                           res_credit_i,
   input  logic                           retire_v_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] retire_rd_i,

   output logic                           r0_v_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] r0_addr_o,
   output logic                           r1_v_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] r1_addr_o,
   output logic                           r2_v_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] r2_addr_o,

   output logic                           iss_v_o,
   output mac_pkg::mac_op_e               iss_op_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] iss_rd_o,
   output logic [mac_pkg::DATA_W-1:0]     iss_imm_o
);

   // input queue storage
   mac_pkg::mac_op_e               q_op_q  [mac_pkg::IN_CREDITS];
   logic [mac_pkg::REG_ADDR_W-1:0] q_rd_q  [mac_pkg::IN_CREDITS];
   logic [mac_pkg::REG_ADDR_W-1:0] q_rs1_q [mac_pkg::IN_CREDITS];
   logic [mac_pkg::REG_ADDR_W-1:0] q_rs2_q [mac_pkg::IN_CREDITS];
   logic [mac_pkg::REG_ADDR_W-1:0] q_rs3_q [mac_pkg::IN_CREDITS];
   logic [mac_pkg::DATA_W-1:0]     q_imm_q [mac_pkg::IN_CREDITS];

   logic [mac_pkg::QPTR_W-1:0]     wr_ptr_q;
   logic [mac_pkg::QPTR_W-1:0]     rd_ptr_q;
   logic [mac_pkg::CREDIT_W-1:0]   q_count_q;
   logic [mac_pkg::CREDIT_W-1:0]   out_credit_q;
   logic [mac_pkg::REG_COUNT-1:0]  busy_q;

   mac_pkg::issue_state_e          state_d;
   mac_pkg::issue_state_e          state_q;

   mac_pkg::mac_op_e               head_op;
   logic [mac_pkg::REG_ADDR_W-1:0] head_rd;
   logic [mac_pkg::REG_ADDR_W-1:0] head_rs1;
   logic [mac_pkg::REG_ADDR_W-1:0] head_rs2;
   logic [mac_pkg::REG_ADDR_W-1:0] head_rs3;
   logic                           use_ab;
   logic                           use_c;
   logic                           hazard;
   logic                           issue_go;

   assign head_op  = q_op_q[rd_ptr_q];
   assign head_rd  = q_rd_q[rd_ptr_q];
   assign head_rs1 = q_rs1_q[rd_ptr_q];
   assign head_rs2 = q_rs2_q[rd_ptr_q];
   assign head_rs3 = q_rs3_q[rd_ptr_q];

   // load reads nothing, mul reads two, madd and msub read three
   assign use_ab = (head_op != mac_pkg::OP_LOAD);
   assign use_c  = (head_op == mac_pkg::OP_MADD) || (head_op == mac_pkg::OP_MSUB);

   // a busy destination also waits, so one busy bit per register is enough
   assign hazard = (use_ab && busy_q[head_rs1]) ||
                   (use_ab && busy_q[head_rs2]) ||
                   (use_c && busy_q[head_rs3]) ||
                   busy_q[head_rd];

   always_comb
   begin
      if (q_count_q == '0)
      begin
         state_d = mac_pkg::ISSUE_IDLE;
      end
      else if (hazard || (out_credit_q == '0))
      begin
         state_d = mac_pkg::ISSUE_WAIT;
      end
      else
      begin
         state_d = mac_pkg::ISSUE_GO;
      end
   end

   assign issue_go = (state_d == mac_pkg::ISSUE_GO);

   // queue write side, payload only
   always_ff @(posedge clk_i)
   begin
      if (in_valid_i)
      begin
         q_op_q[wr_ptr_q]  <= in_op_i;
         q_rd_q[wr_ptr_q]  <= in_rd_i;
         q_rs1_q[wr_ptr_q] <= in_rs1_i;
         q_rs2_q[wr_ptr_q] <= in_rs2_i;
         q_rs3_q[wr_ptr_q] <= in_rs3_i;
         q_imm_q[wr_ptr_q] <= in_imm_i;
      end
   end

   // pointers, occupancy, output credits and state
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q     <= '0;
         rd_ptr_q     <= '0;
         q_count_q    <= '0;
         out_credit_q <= mac_pkg::CREDIT_W'(mac_pkg::OUT_CREDITS);
         state_q      <= mac_pkg::ISSUE_IDLE;
      end
      else
      begin
         state_q <= state_d;
         if (in_valid_i)
         begin
            wr_ptr_q <= (int'(wr_ptr_q) == mac_pkg::IN_CREDITS - 1) ? '0 : wr_ptr_q + 1'b1;
         end
         if (issue_go)
         begin
            rd_ptr_q <= (int'(rd_ptr_q) == mac_pkg::IN_CREDITS - 1) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({in_valid_i, issue_go})
            2'b10:   q_count_q <= q_count_q + 1'b1;
            2'b01:   q_count_q <= q_count_q - 1'b1;
            default: q_count_q <= q_count_q;
         endcase
         // one credit spent per issue, one back per consumer pulse
         case ({res_credit_i, issue_go})
            2'b10:   out_credit_q <= out_credit_q + 1'b1;
            2'b01:   out_credit_q <= out_credit_q - 1'b1;
            default: out_credit_q <= out_credit_q;
         endcase
      end
   end

   // scoreboard, set after clear so an issue wins
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         busy_q <= '0;
      end
      else
      begin
         if (retire_v_i)
         begin
            busy_q[retire_rd_i] <= 1'b0;
         end
         if (issue_go)
         begin
            busy_q[head_rd] <= 1'b1;
         end
      end
   end

   // issue fields, registered when the head leaves
   always_ff @(posedge clk_i)
   begin
      if (issue_go)
      begin
         iss_op_o  <= head_op;
         iss_rd_o  <= head_rd;
         iss_imm_o <= q_imm_q[rd_ptr_q];
         r0_addr_o <= head_rs1;
         r1_addr_o <= head_rs2;
         r2_addr_o <= head_rs3;
      end
   end

   assign iss_v_o     = (state_q == mac_pkg::ISSUE_GO);
   assign in_credit_o = iss_v_o;

   assign r0_v_o = iss_v_o && (iss_op_o != mac_pkg::OP_LOAD);
   assign r1_v_o = iss_v_o && (iss_op_o != mac_pkg::OP_LOAD);
   assign r2_v_o = iss_v_o && ((iss_op_o == mac_pkg::OP_MADD) ||
                               (iss_op_o == mac_pkg::OP_MSUB));

endmodule

`default_nettype wire

//--- design/mac_pkg.sv
`default_nettype none

package mac_pkg;

   // datapath and register file sizes
   localparam int DATA_W     = 32;
   localparam int REG_COUNT  = 16;
   localparam int REG_ADDR_W = 4;

   // three synchronous read ports on the register file
   localparam int READ_PORTS = 3;

   // input queue depth, equal to the credits the sender starts with
   localparam int IN_CREDITS = 2;

   // result slots held by the consumer
   localparam int OUT_CREDITS = 4;

   // wide enough for either credit count
   localparam int CREDIT_W = 3;

   // queue pointer width
   localparam int QPTR_W = $clog2(IN_CREDITS);

   // instruction opcodes
   typedef enum logic [1:0]
   {
      OP_LOAD = 2'b00,
      OP_MUL  = 2'b01,
      OP_MADD = 2'b10,
      OP_MSUB = 2'b11
   } mac_op_e;

   // issue controller states
   // idle means the queue is empty, wait means a hazard or no output credit
   typedef enum logic [1:0]
   {
      ISSUE_IDLE = 2'b00,
      ISSUE_WAIT = 2'b01,
      ISSUE_GO   = 2'b10
   } issue_state_e;

endpackage

`default_nettype wire

//--- design/mac_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_top
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,

   input  logic                           in_valid_i,
   input  mac_pkg::mac_op_e               in_op_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rd_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rs1_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rs2_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] in_rs3_i,
   input  logic [mac_pkg::DATA_W-1:0]     in_imm_i,
   output logic                           in_credit_o,

   output logic                           res_valid_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] res_rd_o,
   output logic [mac_pkg::DATA_W-1:0]     res_data_o,
   input  logic                           res_credit_i
);

   // register file read side
   logic                           r0_v;
   logic                           r1_v;
   logic                           r2_v;
   logic [mac_pkg::REG_ADDR_W-1:0] r0_addr;
   logic [mac_pkg::REG_ADDR_W-1:0] r1_addr;
   logic [mac_pkg::REG_ADDR_W-1:0] r2_addr;
   logic [mac_pkg::DATA_W-1:0]     r0_data;
   logic [mac_pkg::DATA_W-1:0]     r1_data;
   logic [mac_pkg::DATA_W-1:0]     r2_data;

   // write back and retire
   logic                           w_v;
   logic [mac_pkg::REG_ADDR_W-1:0] w_addr;
   logic [mac_pkg::DATA_W-1:0]     w_data;
   logic                           retire_v;
   logic [mac_pkg::REG_ADDR_W-1:0] retire_rd;

   // issue strobe to both lanes
   logic                           iss_v;
   mac_pkg::mac_op_e               iss_op;
   logic [mac_pkg::REG_ADDR_W-1:0] iss_rd;
   logic [mac_pkg::DATA_W-1:0]     iss_imm;

   // lane outputs
   logic                           prod_v;
   logic [mac_pkg::DATA_W-1:0]     prod;
   logic                           add_v;
   logic [mac_pkg::REG_ADDR_W-1:0] add_rd;
   logic [mac_pkg::DATA_W-1:0]     addend;

   regfile_3r1w_sync u_regfile
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_v_i     (w_v),
      .w_addr_i  (w_addr),
      .w_data_i  (w_data),
      .r0_v_i    (r0_v),
      .r0_addr_i (r0_addr),
      .r0_data_o (r0_data),
      .r1_v_i    (r1_v),
      .r1_addr_i (r1_addr),
      .r1_data_o (r1_data),
      .r2_v_i    (r2_v),
      .r2_addr_i (r2_addr),
      .r2_data_o (r2_data)
   );

   issue_ctrl u_issue
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .in_op_i      (in_op_i),
      .in_rd_i      (in_rd_i),
      .in_rs1_i     (in_rs1_i),
      .in_rs2_i     (in_rs2_i),
      .in_rs3_i     (in_rs3_i),
      .in_imm_i     (in_imm_i),
      .in_credit_o  (in_credit_o),
      .res_credit_i (res_credit_i),
      .retire_v_i   (retire_v),
      .retire_rd_i  (retire_rd),
      .r0_v_o       (r0_v),
      .r0_addr_o    (r0_addr),
      .r1_v_o       (r1_v),
      .r1_addr_o    (r1_addr),
      .r2_v_o       (r2_v),
      .r2_addr_o    (r2_addr),
      .iss_v_o      (iss_v),
      .iss_op_o     (iss_op),
      .iss_rd_o     (iss_rd),
      .iss_imm_o    (iss_imm)
   );

   mul_lane u_mul
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .iss_v_i    (iss_v),
      .iss_op_i   (iss_op),
      .rs1_data_i (r0_data),
      .rs2_data_i (r1_data),
      .prod_v_o   (prod_v),
      .prod_o     (prod)
   );

   addend_lane u_addend
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .iss_v_i    (iss_v),
      .iss_op_i   (iss_op),
      .iss_rd_i   (iss_rd),
      .iss_imm_i  (iss_imm),
      .rs3_data_i (r2_data),
      .add_v_o    (add_v),
      .add_rd_o   (add_rd),
      .addend_o   (addend)
   );

   result_combine u_combine
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .prod_v_i    (prod_v),
      .prod_i      (prod),
      .add_v_i     (add_v),
      .add_rd_i    (add_rd),
      .addend_i    (addend),
      .res_valid_o (res_valid_o),
      .res_rd_o    (res_rd_o),
      .res_data_o  (res_data_o),
      .w_v_o       (w_v),
      .w_addr_o    (w_addr),
      .w_data_o    (w_data),
      .retire_v_o  (retire_v),
      .retire_rd_o (retire_rd)
   );

endmodule

`default_nettype wire

//--- design/mul_lane.sv
`timescale 1ns/1ps
`default_nettype none

module mul_lane
(
   input  logic                       clk_i,
   input  logic                       rst_n_i,

   input  logic                       iss_v_i,
   input  mac_pkg::mac_op_e           iss_op_i,
   input  logic [mac_pkg::DATA_W-1:0] rs1_data_i,
   input  logic [mac_pkg::DATA_W-1:0] rs2_data_i,

   output logic                       prod_v_o,
   output logic [mac_pkg::DATA_W-1:0] prod_o
);

   logic                       v_q;
   mac_pkg::mac_op_e           op_q;
   logic [mac_pkg::DATA_W-1:0] prod_lo;

   // low word only, same for signed and unsigned operands
   assign prod_lo = rs1_data_i * rs2_data_i;

   // stage valids
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         v_q      <= 1'b0;
         prod_v_o <= 1'b0;
      end
      else
      begin
         v_q      <= iss_v_i;
         prod_v_o <= v_q;
      end
   end

   // opcode waits one cycle for the read data
   always_ff @(posedge clk_i)
   begin
      if (iss_v_i)
      begin
         op_q <= iss_op_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (v_q)
      begin
         // a load takes nothing from this lane
         prod_o <= (op_q == mac_pkg::OP_LOAD) ? '0 : prod_lo;
      end
   end

endmodule

`default_nettype wire

//--- design/regfile_3r1w_sync.sv
`timescale 1ns/1ps
`default_nettype none

module regfile_3r1w_sync
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,

   input  logic                           w_v_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] w_addr_i,
   input  logic [mac_pkg::DATA_W-1:0]     w_data_i,

   input  logic                           r0_v_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] r0_addr_i,
   output logic [mac_pkg::DATA_W-1:0]     r0_data_o,

   input  logic                           r1_v_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] r1_addr_i,
   output logic [mac_pkg::DATA_W-1:0]     r1_data_o,

   input  logic                           r2_v_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] r2_addr_i,
   output logic [mac_pkg::DATA_W-1:0]     r2_data_o
);

   logic [mac_pkg::DATA_W-1:0]     mem_q     [mac_pkg::REG_COUNT];
   logic                           rd_v      [mac_pkg::READ_PORTS];
   logic [mac_pkg::REG_ADDR_W-1:0] rd_addr   [mac_pkg::READ_PORTS];
   logic [mac_pkg::DATA_W-1:0]     rd_data_q [mac_pkg::READ_PORTS];

   // gather the read ports so one loop serves all three
   assign rd_v[0]    = r0_v_i;
   assign rd_v[1]    = r1_v_i;
   assign rd_v[2]    = r2_v_i;
   assign rd_addr[0] = r0_addr_i;
   assign rd_addr[1] = r1_addr_i;
   assign rd_addr[2] = r2_addr_i;

   // register contents start at zero
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < mac_pkg::REG_COUNT; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (w_v_i)
      begin
         mem_q[w_addr_i] <= w_data_i;
      end
   end

   // read sees the array before this cycle's write lands
   // a port holds its last word while idle
   always_ff @(posedge clk_i)
   begin
      for (int p = 0; p < mac_pkg::READ_PORTS; p++)
      begin
         if (rd_v[p])
         begin
            rd_data_q[p] <= mem_q[rd_addr[p]];
         end
      end
   end

   assign r0_data_o = rd_data_q[0];
   assign r1_data_o = rd_data_q[1];
   assign r2_data_o = rd_data_q[2];

endmodule

`default_nettype wire

//--- design/result_combine.sv
`timescale 1ns/1ps
`default_nettype none

module result_combine
(
   input  logic                           clk_i,
   input  logic                           rst_n_i,

   input  logic                           prod_v_i,
   input  logic [mac_pkg::DATA_W-1:0]     prod_i,
   input  logic                           add_v_i,
   input  logic [mac_pkg::REG_ADDR_W-1:0] add_rd_i,
   input  logic [mac_pkg::DATA_W-1:0]     addend_i,

   output logic                           res_valid_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] res_rd_o,
   output logic [mac_pkg::DATA_W-1:0]     res_data_o,

   output logic                           w_v_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] w_addr_o,
   output logic [mac_pkg::DATA_W-1:0]     w_data_o,

   output logic                           retire_v_o,
   output logic [mac_pkg::REG_ADDR_W-1:0] retire_rd_o
);

   logic                           both_v;
   logic [mac_pkg::DATA_W-1:0]     sum;
   logic                           res_v_q;
   logic [mac_pkg::REG_ADDR_W-1:0] rd_q;
   logic [mac_pkg::DATA_W-1:0]     sum_q;

   // lanes run in lockstep, so both valids rise together
   assign both_v = prod_v_i && add_v_i;

   // wraps modulo 2^32
   assign sum = prod_i + addend_i;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         res_v_q <= 1'b0;
      end
      else
      begin
         res_v_q <= both_v;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (both_v)
      begin
         sum_q <= sum;
         rd_q  <= add_rd_i;
      end
   end

   // one strobe drives the result port, the write back and the retire
   assign res_valid_o = res_v_q;
   assign res_rd_o    = rd_q;
   assign res_data_o  = sum_q;

   assign w_v_o    = res_v_q;
   assign w_addr_o = rd_q;
   assign w_data_o = sum_q;

   // scoreboard clears this destination at the end of the cycle
   assign retire_v_o  = res_v_q;
   assign retire_rd_o = rd_q;

endmodule

`default_nettype wire

//--- dv/mac_stimulus.txt
# columns in hex: op rd rs1 rs2 rs3 imm expected_result
# op 0 load, 1 mul, 2 madd, 3 msub; results wrap modulo 2^32
1 1 2 3 0 00000000 00000000
2 4 5 6 7 00000000 00000000
0 1 0 0 0 00000007 00000007
0 2 0 0 0 00000006 00000006
1 3 1 2 0 00000000 0000002a
0 4 0 0 0 00000005 00000005
2 5 1 2 4 00000000 0000002f
3 6 1 2 4 00000000 00000025
3 7 0 0 4 00000000 fffffffb
0 8 0 0 0 ffffffff ffffffff
1 9 8 8 0 00000000 00000001
1 a 8 1 0 00000000 fffffff9
0 b 0 0 0 80000000 80000000
1 c b 2 0 00000000 00000000
0 d 0 0 0 00010000 00010000
2 e d d 8 00000000 ffffffff
3 f d d 3 00000000 ffffffd6
2 0 b b b 00000000 80000000
0 1 0 0 0 00000003 00000003
2 2 1 1 1 00000000 0000000c
2 3 2 2 2 00000000 0000009c
3 4 3 3 3 00000000 00005e74
2 5 4 4 4 00000000 22d9c304
0 6 0 0 0 12345678 12345678
0 7 0 0 0 00000010 00000010
1 8 6 7 0 00000000 23456780
2 9 6 7 6 00000000 3579bdf8
3 a 6 7 9 00000000 edcba988
2 b a 7 a 00000000 ca864208
1 c 3 3 0 00000000 00005f10
3 d 0 1 c 00000000 7fffa0f0
0 e 0 0 0 0000abcd 0000abcd
2 f e 1 e 00000000 0002af34
1 1 f 2 0 00000000 00203670
0 3 0 0 0 deadbeef deadbeef
3 4 3 0 3 00000000 a1524111
0 9 0 0 0 0000007f 0000007f
2 a 9 9 9 00000000 00003f80

//--- dv/mac_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mac_unit_tb;

   localparam string STIM_FILE = "dv/mac_stimulus.txt";

   logic                           clk_i;
   logic                           rst_n_i;
   logic                           in_valid_i;
   mac_pkg::mac_op_e               in_op_i;
   logic [mac_pkg::REG_ADDR_W-1:0] in_rd_i;
   logic [mac_pkg::REG_ADDR_W-1:0] in_rs1_i;
   logic [mac_pkg::REG_ADDR_W-1:0] in_rs2_i;
   logic [mac_pkg::REG_ADDR_W-1:0] in_rs3_i;
   logic [mac_pkg::DATA_W-1:0]     in_imm_i;
   logic                           in_credit_o;
   logic                           res_valid_o;
   logic [mac_pkg::REG_ADDR_W-1:0] res_rd_o;
   logic [mac_pkg::DATA_W-1:0]     res_data_o;
   logic                           res_credit_i;

   // instruction table and expected results
   mac_pkg::mac_op_e               op_q   [$];
   logic [mac_pkg::REG_ADDR_W-1:0] rd_q   [$];
   logic [mac_pkg::REG_ADDR_W-1:0] rs1_q  [$];
   logic [mac_pkg::REG_ADDR_W-1:0] rs2_q  [$];
   logic [mac_pkg::REG_ADDR_W-1:0] rs3_q  [$];
   logic [mac_pkg::DATA_W-1:0]     imm_q  [$];
   logic [mac_pkg::DATA_W-1:0]     exp_q  [$];

   int n_instr        = 0;
   int sent_count     = 0;
   int res_count      = 0;
   int in_credits     = mac_pkg::IN_CREDITS;
   int held_count     = 0;
   int returned_count = 0;
   int cycle_count    = 0;
   int cycle_limit    = 0;

   mac_unit_top u_dut
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .in_valid_i   (in_valid_i),
      .in_op_i      (in_op_i),
      .in_rd_i      (in_rd_i),
      .in_rs1_i     (in_rs1_i),
      .in_rs2_i     (in_rs2_i),
      .in_rs3_i     (in_rs3_i),
      .in_imm_i     (in_imm_i),
      .in_credit_o  (in_credit_o),
      .res_valid_o  (res_valid_o),
      .res_rd_o     (res_rd_o),
      .res_data_o   (res_data_o),
      .res_credit_i (res_credit_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_rd(input int idx, input logic [mac_pkg::REG_ADDR_W-1:0] got,
                           input logic [mac_pkg::REG_ADDR_W-1:0] expected);
      if (got !== expected)
      begin
         abort_run($sformatf("Mismatch res_rd_o on result %0d: got %h expected %h",
                             idx, got, expected));
      end
   endtask

   task automatic check_data(input int idx, input logic [mac_pkg::DATA_W-1:0] got,
                             input logic [mac_pkg::DATA_W-1:0] expected);
      if (got !== expected)
      begin
         abort_run($sformatf("Mismatch res_data_o on result %0d: got %h expected %h",
                             idx, got, expected));
      end
   endtask

   // one instruction per line, lines starting with # are skipped
   task automatic read_stimulus();
      int          fd;
      int          fields;
      string       line;
      logic [31:0] f_op;
      logic [31:0] f_rd;
      logic [31:0] f_rs1;
      logic [31:0] f_rs2;
      logic [31:0] f_rs3;
      logic [31:0] f_imm;
      logic [31:0] f_exp;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0)
      begin
         abort_run("could not open the stimulus file");
      end
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 1 && line[0] != "#")
            begin
               fields = $sscanf(line, "%h %h %h %h %h %h %h",
                                f_op, f_rd, f_rs1, f_rs2, f_rs3, f_imm, f_exp);
               if (fields != 7)
               begin
                  abort_run($sformatf("stimulus line has %0d fields instead of 7", fields));
               end
               else
               begin
                  op_q.push_back(mac_pkg::mac_op_e'(f_op[1:0]));
                  rd_q.push_back(f_rd[mac_pkg::REG_ADDR_W-1:0]);
                  rs1_q.push_back(f_rs1[mac_pkg::REG_ADDR_W-1:0]);
                  rs2_q.push_back(f_rs2[mac_pkg::REG_ADDR_W-1:0]);
                  rs3_q.push_back(f_rs3[mac_pkg::REG_ADDR_W-1:0]);
                  imm_q.push_back(f_imm);
                  exp_q.push_back(f_exp);
               end
            end
         end
         $fclose(fd);
         n_instr = op_q.size();
      end
   endtask

   // sender side, one cycle of valid per credit spent
   task automatic send_instr(input int idx);
      while (in_credits == 0)
      begin
         @(posedge clk_i);
         #1;
      end
      in_valid_i = 1'b1;
      in_op_i    = op_q[idx];
      in_rd_i    = rd_q[idx];
      in_rs1_i   = rs1_q[idx];
      in_rs2_i   = rs2_q[idx];
      in_rs3_i   = rs3_q[idx];
      in_imm_i   = imm_q[idx];
      in_credits = in_credits - 1;
      sent_count = sent_count + 1;
      @(posedge clk_i);
      #1;
      in_valid_i = 1'b0;
   endtask

   initial
   begin
      int gap;
      rst_n_i    = 1'b0;
      in_valid_i = 1'b0;
      in_op_i    = mac_pkg::OP_LOAD;
      in_rd_i    = '0;
      in_rs1_i   = '0;
      in_rs2_i   = '0;
      in_rs3_i   = '0;
      in_imm_i   = '0;
      void'($urandom(24));
      read_stimulus();
      cycle_limit = n_instr * 20 + 100;
      repeat (4) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      for (int i = 0; i < n_instr; i++)
      begin
         send_instr(i);
         gap = $urandom_range(3, 0);
         repeat (gap)
         begin
            @(posedge clk_i);
            #1;
         end
      end
      wait (res_count == n_instr);
      repeat (2) @(posedge clk_i);
      if (in_credits == mac_pkg::IN_CREDITS)
      begin
         $display("Test OK");
         $finish;
      end
      else
      begin
         abort_run($sformatf("sender holds %0d input credits at the end", in_credits));
      end
   end

   // consumer frees one slot per credit pulse
   initial
   begin
      int delay;
      res_credit_i = 1'b0;
      wait (rst_n_i === 1'b1);
      forever
      begin
         @(posedge clk_i);
         #1;
         if (held_count > 0)
         begin
            delay = $urandom_range(6, 0);
            // long hold here so the unit runs out of output credits
            if (returned_count >= 10 && returned_count < 14)
            begin
               delay = 30;
            end
            repeat (delay)
            begin
               @(posedge clk_i);
               #1;
            end
            res_credit_i   = 1'b1;
            held_count     = held_count - 1;
            returned_count = returned_count + 1;
            @(posedge clk_i);
            #1;
            res_credit_i = 1'b0;
         end
      end
   end

   // outputs sampled mid cycle
   always @(negedge clk_i)
   begin
      if (in_credit_o)
      begin
         in_credits = in_credits + 1;
         if (in_credits > mac_pkg::IN_CREDITS)
         begin
            abort_run("sender credit count went above its start value");
         end
      end
      if (res_valid_o)
      begin
         if (sent_count == res_count)
         begin
            abort_run("a result arrived with no instruction outstanding");
         end
         else
         begin
            check_rd(res_count, res_rd_o, rd_q[res_count]);
            check_data(res_count, res_data_o, exp_q[res_count]);
            res_count  = res_count + 1;
            held_count = held_count + 1;
            if (held_count > mac_pkg::OUT_CREDITS)
            begin
               abort_run("a result arrived while the consumer had no free slot");
            end
         end
      end
   end

   always @(posedge clk_i)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         abort_run($sformatf("timeout after %0d cycles with %0d of %0d results",
                             cycle_count, res_count, n_instr));
      end
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the MAC unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f sim.f \
   --top-module mac_unit_tb -o mac_unit_sim

sim_out=$(./obj_dir/mac_unit_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^Test OK$"; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- sim.f
design/mac_pkg.sv
design/regfile_3r1w_sync.sv
design/issue_ctrl.sv
design/mul_lane.sv
design/addend_lane.sv
design/result_combine.sv
design/mac_unit_top.sv
dv/mac_unit_tb.sv
